//--- hw/rp_pkg.sv
package rp_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned ADC_DW      = 14;  // ADC and DAC sample width
  localparam int unsigned ADC_LSB_RSV = 2;   // low bits kept for a 16 bit converter
  localparam int unsigned PDM_DW      = 8;   // PDM level width
  localparam int unsigned REG_AW      = 4;   // word address
  localparam int unsigned REG_DW      = 16;

  typedef logic signed [ADC_DW-1:0] smp_t;      // two's complement sample
  typedef logic        [PDM_DW-1:0] pdm_lvl_t;  // density level
  typedef logic        [REG_AW-1:0] reg_addr_t;
  typedef logic        [REG_DW-1:0] reg_data_t;

  //////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////

  localparam reg_addr_t ADDR_LOOP = 4'd0;  // loopback enables
  localparam reg_addr_t ADDR_DAC0 = 4'd1;  // DAC levels follow
  localparam reg_addr_t ADDR_DAC1 = 4'd2;
  localparam reg_addr_t ADDR_PDM0 = 4'd3;  // PDM levels, up to four

  //////////////////////////////////////////////////
  // system bus, four phase req/ack
  //////////////////////////////////////////////////

  typedef struct packed {
    logic      req;    // held until ack
    logic      we;     // 1 write, 0 read
    reg_addr_t addr;
    reg_data_t wdata;
  } sys_req_t;

  typedef struct packed {
    logic      ack;
    logic      err;    // unmapped address
    reg_data_t rdata;  // valid with ack
  } sys_rsp_t;

endpackage

//--- hw/sys_regs.sv
`timescale 1ns/1ps

module sys_regs import rp_pkg::*; #(
  parameter int unsigned ADC_CHN = 2,  // analog channels
  parameter int unsigned PDM_CHN = 4   // PDM channels, max 4
) (
  input  logic                    adc_clk,
  input  logic                    top_rst,
  // system bus
  input  sys_req_t                sys_req_i,
  output sys_rsp_t                sys_rsp_o,
  // configuration
  output logic     [ADC_CHN-1:0]  loop_en_o,  // per channel loopback
  output smp_t     [ADC_CHN-1:0]  dac_lvl_o,
  output pdm_lvl_t [PDM_CHN-1:0]  pdm_lvl_o
);

  // handshake state
  typedef enum logic {
    ST_IDLE,  // waiting for req
    ST_ACK    // ack high until req drops
  } hs_st_t;

  hs_st_t st;

  logic               ack;
  logic               err_q;
  reg_data_t          rdata_q;
  logic               acc_go;  // access happens at this edge
  logic               acc_hit;
  reg_data_t          acc_rdat;
  logic               sel_loop;
  logic [ADC_CHN-1:0] sel_dac;
  logic [PDM_CHN-1:0] sel_pdm;

  //////////////////////////////////////////////////
  // address decode and read mux
  //////////////////////////////////////////////////

  always_comb begin
    sel_loop = (sys_req_i.addr == ADDR_LOOP);
    for (int i = 0; i < ADC_CHN; i++) begin
      sel_dac[i] = (sys_req_i.addr == reg_addr_t'(ADDR_DAC0 + i));
    end
    for (int i = 0; i < PDM_CHN; i++) begin
      sel_pdm[i] = (sys_req_i.addr == reg_addr_t'(ADDR_PDM0 + i));
    end
  end

  assign acc_hit = sel_loop | (|sel_dac) | (|sel_pdm);

  always_comb begin
    acc_rdat = '0;  // unmapped reads as zero
    if (sel_loop) acc_rdat[ADC_CHN-1:0] = loop_en_o;
    for (int i = 0; i < ADC_CHN; i++) begin
      if (sel_dac[i]) acc_rdat[ADC_DW-1:0] = dac_lvl_o[i];  // 14 bits, no sign ext
    end
    for (int i = 0; i < PDM_CHN; i++) begin
      if (sel_pdm[i]) acc_rdat[PDM_DW-1:0] = pdm_lvl_o[i];
    end
  end

  //////////////////////////////////////////////////
  // handshake and register writes
  //////////////////////////////////////////////////

  assign acc_go = (st == ST_IDLE) && sys_req_i.req;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      st        <= ST_IDLE;
      err_q     <= 1'b0;
      loop_en_o <= '0;
      dac_lvl_o <= '0;
      pdm_lvl_o <= '0;
    end else begin
      case (st)
        ST_IDLE: if (sys_req_i.req) begin
          st    <= ST_ACK;
          err_q <= ~acc_hit;
          if (sys_req_i.we) begin  // only the addressed field moves
            if (sel_loop) loop_en_o <= sys_req_i.wdata[ADC_CHN-1:0];
            for (int i = 0; i < ADC_CHN; i++) begin
              if (sel_dac[i]) dac_lvl_o[i] <= smp_t'(sys_req_i.wdata[ADC_DW-1:0]);
            end
            for (int i = 0; i < PDM_CHN; i++) begin
              if (sel_pdm[i]) pdm_lvl_o[i] <= sys_req_i.wdata[PDM_DW-1:0];
            end
          end
        end
        ST_ACK: if (!sys_req_i.req) st <= ST_IDLE;  // phase 4
        default: st <= ST_IDLE;
      endcase
    end
  end

  // read data held until next access
  always_ff @(posedge adc_clk) begin
    if (acc_go) rdata_q <= acc_rdat;
  end

  assign ack       = (st == ST_ACK);
  assign sys_rsp_o = '{ack: ack, err: err_q, rdata: rdata_q};

  // master keeps addr/we steady until the access edge
  a_req_stable: assert property (@(posedge adc_clk) disable iff (top_rst)
    (sys_req_i.req && !ack) |=> (!sys_req_i.req ||
      ($stable(sys_req_i.addr) && $stable(sys_req_i.we))));

  a_ack_req: assert property (@(posedge adc_clk) disable iff (top_rst)
    $rose(ack) |-> $past(sys_req_i.req));

endmodule

//--- hw/analog_io.sv
`timescale 1ns/1ps

module analog_io import rp_pkg::*; #(
  parameter int unsigned ADC_CHN = 2  // analog channels
) (
  input  logic                           adc_clk,
  input  logic                           top_rst,
  // ADC side
  input  smp_t [ADC_CHN-1:0]             adc_dat_i,  // parallel converter words
  input  logic [ADC_CHN-1:0]             loop_en_i,
  input  smp_t [ADC_CHN-1:0]             dac_lvl_i,  // signed levels from registers
  output smp_t [ADC_CHN-1:0]             adc_smp_o,
  // DAC side
  output logic [ADC_CHN-1:0][ADC_DW-1:0] dac_dat_o,  // offset binary
  output logic                           dac_reset_o
);

  localparam logic [ADC_DW-1:0] DAC_MID = {1'b1, {(ADC_DW-1){1'b0}}};

  smp_t [ADC_CHN-1:0] adc_cap;  // first pipeline stage

  //////////////////////////////////////////////////
  // ADC capture
  //////////////////////////////////////////////////

  // reserved low bits cleared on the way in
  always_ff @(posedge adc_clk) begin
    for (int i = 0; i < ADC_CHN; i++) begin
      adc_cap[i] <= {adc_dat_i[i][ADC_DW-1:ADC_LSB_RSV], {ADC_LSB_RSV{1'b0}}};
    end
  end

  // loopback mux sits in front of the output register
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_smp_o <= '0;
    end else begin
      for (int i = 0; i < ADC_CHN; i++) begin
        adc_smp_o[i] <= loop_en_i[i] ? dac_lvl_i[i] : adc_cap[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // DAC output
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= {ADC_CHN{DAC_MID}};  // zero level
    end else begin
      for (int i = 0; i < ADC_CHN; i++) begin
        // signed to offset binary
        dac_dat_o[i] <= {~dac_lvl_i[i][ADC_DW-1], dac_lvl_i[i][ADC_DW-2:0]};
      end
    end
  end

  // converter held in reset one cycle past top_rst
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) dac_reset_o <= 1'b1;
    else         dac_reset_o <= 1'b0;
  end

  // samples are clean once the converter is released
  a_smp_known: assert property (@(posedge adc_clk)
    !dac_reset_o |-> !$isunknown(adc_smp_o));

endmodule

//--- hw/pdm_mod.sv
`timescale 1ns/1ps

module pdm_mod import rp_pkg::*; #(
  parameter int unsigned PDM_CHN = 4  // output channels
) (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  pdm_lvl_t [PDM_CHN-1:0]   pdm_lvl_i,  // density, level/256
  output logic     [PDM_CHN-1:0]   pdm_o
);

  //////////////////////////////////////////////////
  // first order modulator
  //////////////////////////////////////////////////

  pdm_lvl_t [PDM_CHN-1:0] acc;              // phase accumulators
  logic     [PDM_CHN-1:0][PDM_DW:0] acc_sum;  // sum with carry on top

  always_comb begin
    for (int i = 0; i < PDM_CHN; i++) begin
      acc_sum[i] = {1'b0, acc[i]} + {1'b0, pdm_lvl_i[i]};
    end
  end

  // carry out is the pulse
  // over 256 steady cycles the carries add up to the level exactly
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      acc   <= '0;
      pdm_o <= '0;
    end else begin
      for (int i = 0; i < PDM_CHN; i++) begin
        acc[i]   <= acc_sum[i][PDM_DW-1:0];  // wraps mod 256
        pdm_o[i] <= acc_sum[i][PDM_DW];
      end
    end
  end

endmodule

//--- hw/rp_top.sv
`timescale 1ns/1ps

module rp_top import rp_pkg::*; #(
  parameter int unsigned ADC_CHN = 2,  // analog channels
  parameter int unsigned PDM_CHN = 4   // PDM outputs, fits map up to 4
) (
  input  logic                           adc_clk,
  input  logic                           top_rst,
  // system bus
  input  sys_req_t                       sys_req_i,
  output sys_rsp_t                       sys_rsp_o,
  // ADC
  input  smp_t [ADC_CHN-1:0]             adc_dat_i,
  output smp_t [ADC_CHN-1:0]             adc_smp_o,
  // DAC
  output logic [ADC_CHN-1:0][ADC_DW-1:0] dac_dat_o,
  output logic                           dac_reset_o,
  // PDM analog outputs
  output logic [PDM_CHN-1:0]             dac_pwm_o
);

  //////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////

  logic     [ADC_CHN-1:0] loop_en;  // digital loopback per channel
  smp_t     [ADC_CHN-1:0] dac_lvl;
  pdm_lvl_t [PDM_CHN-1:0] pdm_lvl;

  sys_regs #(
    .ADC_CHN (ADC_CHN),
    .PDM_CHN (PDM_CHN)
  ) u_regs (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .loop_en_o (loop_en),
    .dac_lvl_o (dac_lvl),
    .pdm_lvl_o (pdm_lvl)
  );

  //////////////////////////////////////////////////
  // ADC and DAC path
  //////////////////////////////////////////////////

  analog_io #(
    .ADC_CHN (ADC_CHN)
  ) u_aio (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat_i),
    .loop_en_i   (loop_en),
    .dac_lvl_i   (dac_lvl),
    .adc_smp_o   (adc_smp_o),
    .dac_dat_o   (dac_dat_o),
    .dac_reset_o (dac_reset_o)
  );

  // slow analog outputs
  pdm_mod #(
    .PDM_CHN (PDM_CHN)
  ) u_pdm (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .pdm_lvl_i (pdm_lvl),
    .pdm_o     (dac_pwm_o)
  );

endmodule

//--- sim/tb_top.sv
`timescale 1ns/1ps

module tb_top import rp_pkg::*; ();

  localparam int ADC_CHN = 2;
  localparam int PDM_CHN = 4;
  localparam int NROW    = 29;  // table rows
  localparam int BUS_TMO = 20;  // cycles per handshake phase
  localparam int NSMP    = 40;  // ADC samples per stream

  // one bus access and its expected response
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    reg_data_t wdata;
    reg_data_t rdata;  // checked on reads and unmapped accesses
    logic      err;
  } row_t;

  logic                           adc_clk;
  logic                           top_rst;
  sys_req_t                       sys_req;
  sys_rsp_t                       sys_rsp;
  smp_t [ADC_CHN-1:0]             adc_dat;
  smp_t [ADC_CHN-1:0]             adc_smp;
  logic [ADC_CHN-1:0][ADC_DW-1:0] dac_dat;
  logic                           dac_reset;
  logic [PDM_CHN-1:0]             dac_pwm;

  row_t        tbl [NROW];
  smp_t        hist [ADC_CHN][NSMP];  // driven samples per channel
  int          pdm_exp [PDM_CHN];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;

  rp_top #(
    .ADC_CHN (ADC_CHN),
    .PDM_CHN (PDM_CHN)
  ) u_dut (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .adc_dat_i   (adc_dat),
    .adc_smp_o   (adc_smp),
    .dac_dat_o   (dac_dat),
    .dac_reset_o (dac_reset),
    .dac_pwm_o   (dac_pwm)
  );

  always #20 adc_clk = ~adc_clk;  // 40 ns period

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // converter word with the reserved low bits cleared
  function automatic logic [ADC_DW-1:0] strip_low(input smp_t s);
    logic [ADC_DW-1:0] m;
    m = '1;
    m[ADC_LSB_RSV-1:0] = '0;
    return unsigned'(s) & m;
  endfunction

  // offset binary is the signed level plus half scale
  function automatic logic [ADC_DW-1:0] offset_code(input smp_t s);
    return unsigned'(s) + ADC_DW'(1 << (ADC_DW - 1));
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s exp %h got %h", name, exp, got);
    end
  endtask

  // four phase access, each wait bounded
  task automatic bus_access(input logic we, input reg_addr_t addr, input reg_data_t wdata,
                            output reg_data_t rdata, output logic err);
    int cnt;
    @(posedge adc_clk);
    #2;
    sys_req = '{req: 1'b1, we: we, addr: addr, wdata: wdata};  // phase 1
    cnt = 0;
    while (!sys_rsp.ack && cnt < BUS_TMO) begin
      @(posedge adc_clk);
      #2;
      cnt++;
    end
    if (!sys_rsp.ack) begin
      errors++;
      $display("bus timeout, no ack for the access to address %h", addr);
    end
    rdata       = sys_rsp.rdata;  // phase 2
    err         = sys_rsp.err;
    sys_req.req = 1'b0;           // phase 3
    cnt = 0;
    while (sys_rsp.ack && cnt < BUS_TMO) begin
      @(posedge adc_clk);
      #2;
      cnt++;
    end
    if (sys_rsp.ack) begin
      errors++;
      $display("bus timeout, ack stayed high after the access to address %h", addr);
    end
  endtask

  // LCG samples in, two cycle delayed samples out
  task automatic stream_adc(input int n, input logic loop1, input smp_t lvl1);
    for (int k = 0; k < n; k++) begin
      @(posedge adc_clk);
      #2;
      if (k >= 2) begin
        check("adc_smp_o[0]", 32'(strip_low(hist[0][k-2])), 32'(unsigned'(adc_smp[0])));
        if (loop1) begin
          check("adc_smp_o[1]", 32'(unsigned'(lvl1)), 32'(unsigned'(adc_smp[1])));
        end else begin
          check("adc_smp_o[1]", 32'(strip_low(hist[1][k-2])), 32'(unsigned'(adc_smp[1])));
        end
      end
      for (int c = 0; c < ADC_CHN; c++) begin
        lcg_state  = lcg_next(lcg_state);
        hist[c][k] = smp_t'(lcg_state[29:16]);
        adc_dat[c] = hist[c][k];
      end
    end
  endtask

  task automatic load_table();
    for (int r = 0; r < 7; r++) begin
      tbl[r] = '{1'b0, reg_addr_t'(r), 16'h0000, 16'h0000, 1'b0};  // reset values
    end
    tbl[7]  = '{1'b1, ADDR_LOOP, 16'hfffe, 16'h0000, 1'b0};
    tbl[8]  = '{1'b0, ADDR_LOOP, 16'h0000, 16'h0002, 1'b0};  // two channel bits
    tbl[9]  = '{1'b1, ADDR_DAC0, 16'hc123, 16'h0000, 1'b0};
    tbl[10] = '{1'b0, ADDR_DAC0, 16'h0000, 16'h0123, 1'b0};  // 14 bit field
    tbl[11] = '{1'b1, ADDR_DAC1, 16'h2abc, 16'h0000, 1'b0};
    tbl[12] = '{1'b0, ADDR_DAC1, 16'h0000, 16'h2abc, 1'b0};
    tbl[13] = '{1'b1, ADDR_PDM0, 16'hab00, 16'h0000, 1'b0};
    tbl[14] = '{1'b1, reg_addr_t'(ADDR_PDM0 + 1), 16'hff01, 16'h0000, 1'b0};
    tbl[15] = '{1'b1, reg_addr_t'(ADDR_PDM0 + 2), 16'h0080, 16'h0000, 1'b0};
    tbl[16] = '{1'b1, reg_addr_t'(ADDR_PDM0 + 3), 16'h12ff, 16'h0000, 1'b0};
    tbl[17] = '{1'b0, ADDR_PDM0, 16'h0000, 16'h0000, 1'b0};
    tbl[18] = '{1'b0, reg_addr_t'(ADDR_PDM0 + 1), 16'h0000, 16'h0001, 1'b0};
    tbl[19] = '{1'b0, reg_addr_t'(ADDR_PDM0 + 2), 16'h0000, 16'h0080, 1'b0};
    tbl[20] = '{1'b0, reg_addr_t'(ADDR_PDM0 + 3), 16'h0000, 16'h00ff, 1'b0};
    tbl[21] = '{1'b1, 4'd7, 16'hffff, 16'h0000, 1'b1};   // unmapped
    tbl[22] = '{1'b0, 4'd15, 16'h0000, 16'h0000, 1'b1};
    tbl[23] = '{1'b1, 4'd15, 16'h5555, 16'h0000, 1'b1};
    tbl[24] = '{1'b0, ADDR_LOOP, 16'h0000, 16'h0002, 1'b0};  // nothing moved
    tbl[25] = '{1'b0, ADDR_DAC0, 16'h0000, 16'h0123, 1'b0};
    tbl[26] = '{1'b0, reg_addr_t'(ADDR_PDM0 + 3), 16'h0000, 16'h00ff, 1'b0};
    tbl[27] = '{1'b1, ADDR_LOOP, 16'h0000, 16'h0000, 1'b0};  // loopback off
    tbl[28] = '{1'b0, ADDR_LOOP, 16'h0000, 16'h0000, 1'b0};
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    reg_data_t rd;
    logic      er;
    int        hi;
    int        idx;
    smp_t      lvl;
    int        hi_cnt [PDM_CHN];
    adc_clk   = 1'b0;
    top_rst   = 1'b1;
    sys_req   = '0;
    adc_dat   = '0;
    errors    = 0;
    checks    = 0;
    lcg_state = 32'd52;  // seed
    load_table();
    repeat (10) @(posedge adc_clk);
    #2;
    check("dac_reset_o", 32'd1, 32'(dac_reset));  // held through reset
    // reset values, DAC parked at midscale
    for (int c = 0; c < ADC_CHN; c++) begin
      check($sformatf("dac_dat_o[%0d]", c), 32'(1 << (ADC_DW - 1)), 32'(dac_dat[c]));
      check($sformatf("adc_smp_o[%0d]", c), 32'd0, 32'(unsigned'(adc_smp[c])));
    end
    top_rst = 1'b0;

    @(posedge adc_clk);
    #2;
    check("dac_reset_o", 32'd0, 32'(dac_reset));
    hi = 0;
    repeat (256) begin
      @(posedge adc_clk);
      #2;
      if (dac_pwm != '0) hi++;
    end
    check("dac_pwm_o high cycles after reset", 32'd0, 32'(hi));

    // register table
    for (int c = 0; c < PDM_CHN; c++) begin
      pdm_exp[c] = 0;
    end
    for (int r = 0; r < NROW; r++) begin
      bus_access(tbl[r].we, tbl[r].addr, tbl[r].wdata, rd, er);
      check($sformatf("sys_rsp_o.err row %0d", r), 32'(tbl[r].err), 32'(er));
      if (!tbl[r].we || tbl[r].err) begin
        check($sformatf("sys_rsp_o.rdata row %0d", r), 32'(tbl[r].rdata), 32'(rd));
      end
      idx = int'(tbl[r].addr) - int'(ADDR_PDM0);
      if (tbl[r].we && !tbl[r].err && idx >= 0 && idx < PDM_CHN) begin
        pdm_exp[idx] = int'(tbl[r].wdata[PDM_DW-1:0]);  // level field only
      end
    end

    stream_adc(NSMP, 1'b0, '0);  // pass through

    // DAC code and loopback on channel 1
    lvl = smp_t'(14'h2345);  // negative level
    bus_access(1'b1, ADDR_DAC1, reg_data_t'(unsigned'(lvl)), rd, er);
    check("sys_rsp_o.err dac1 write", 32'd0, 32'(er));
    bus_access(1'b1, ADDR_LOOP, 16'h0002, rd, er);
    check("sys_rsp_o.err loop write", 32'd0, 32'(er));
    stream_adc(16, 1'b1, lvl);
    check("dac_dat_o[1]", 32'(offset_code(lvl)), 32'(dac_dat[1]));
    check("dac_dat_o[0]", 32'(offset_code(smp_t'(14'h0123))), 32'(dac_dat[0]));

    // PDM density over one full accumulator period
    repeat (300) @(posedge adc_clk);
    for (int c = 0; c < PDM_CHN; c++) begin
      hi_cnt[c] = 0;
    end
    repeat (256) begin
      @(posedge adc_clk);
      #2;
      for (int c = 0; c < PDM_CHN; c++) begin
        if (dac_pwm[c]) hi_cnt[c]++;
      end
    end
    for (int c = 0; c < PDM_CHN; c++) begin
      check($sformatf("dac_pwm_o[%0d] high cycles", c), 32'(pdm_exp[c]), 32'(hi_cnt[c]));
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
hw/rp_pkg.sv
hw/sys_regs.sv
hw/analog_io.sv
hw/pdm_mod.sv
hw/rp_top.sv
sim/tb_top.sv

//--- Makefile
# Verilator flow for rp_top and its testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= RESULT: PASS
VFLAGS    ?= --timing --assert

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass or fail comes from the log, not the exit code of the binary
sim: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
